// File: design/display_pkg.sv
`default_nettype none

package display_pkg;

    // Pixel field widths and frame memory address width
    localparam int COLOUR_W = 9;
    localparam int X_W      = 8;
    localparam int Y_W      = 7;
    localparam int ADDR_W   = 15;

    // Frame width, used as the row stride of the frame memory
    localparam int SCREEN_W = 160;

    // Overlay window
    localparam int BANNER_X      = 40;
    localparam int BANNER_Y      = 50;
    localparam int BANNER_W      = 8;
    localparam int BANNER_H      = 4;
    localparam int BANNER_PIXELS = BANNER_W * BANNER_H;

    // Window counter widths
    localparam int BCOL_W = $clog2(BANNER_W);
    localparam int BROW_W = $clog2(BANNER_H);
    localparam int BIDX_W = $clog2(BANNER_PIXELS);

    // Banner display time in clocks, about ten million on the board
    localparam int HOLD_CYCLES = 16;
    localparam int HOLD_W      = $clog2(HOLD_CYCLES + 1);

    typedef enum logic [3:0] {
        idle         = 4'd0,
        scr_start    = 4'd1,
        scr_s1_begin = 4'd2,
        scr_s1_clear = 4'd3,
        scr_s2_begin = 4'd4,
        scr_s2_clear = 4'd5,
        scr_s3_begin = 4'd6,
        scr_s3_clear = 4'd7,
        scr_win      = 4'd8,
        scr_lose     = 4'd9
    } screen_e;

    // Same bit layout as the VGA colour and coordinate word
    typedef struct packed {
        logic [COLOUR_W-1:0] colour;
        logic [X_W-1:0]      x;
        logic [Y_W-1:0]      y;
    } pixel_t;

    // Base colour per screen code, idle entry unused
    localparam logic [COLOUR_W-1:0] banner_base [0:9] = '{
        9'h000, 9'h1f8, 9'h0c7, 9'h038, 9'h1c0,
        9'h03f, 9'h1b6, 9'h0db, 9'h1ff, 9'h124
    };

endpackage

`default_nettype wire

// File: design/banner_drawer.sv
`timescale 1ns/1ps
`default_nettype none

module banner_drawer (
    input  wire logic                 clk,
    input  wire logic                 resetn,
    input  wire logic                 start,
    input  display_pkg::screen_e      screen,
    output display_pkg::pixel_t       pixel,
    output logic                      valid,
    output logic                      done
);
    import display_pkg::*;

    logic              busy;
    logic [BCOL_W-1:0] col;
    logic [BROW_W-1:0] row;
    logic [BIDX_W-1:0] idx;
    logic              last;

    assign last = (col == BCOL_W'(BANNER_W - 1)) && (row == BROW_W'(BANNER_H - 1));

    // Row-major walk over the window, one pixel per clock
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            col  <= '0;
            row  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            col  <= '0;
            row  <= '0;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
                col  <= '0;
                row  <= '0;
            end else if (col == BCOL_W'(BANNER_W - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Pixel index within the window
    assign idx = BIDX_W'(row) * BIDX_W'(BANNER_W) + BIDX_W'(col);

    always_comb begin
        pixel.colour = banner_base[screen] ^ COLOUR_W'(idx);
        pixel.x      = X_W'(BANNER_X) + X_W'(col);
        pixel.y      = Y_W'(BANNER_Y) + Y_W'(row);
    end

    assign valid = busy;
    // High together with the last pixel
    assign done  = busy && last;

endmodule

`default_nettype wire

// File: design/region_restorer.sv
`timescale 1ns/1ps
`default_nettype none

module region_restorer (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire logic                         start,
    input  wire logic [display_pkg::COLOUR_W-1:0] curr_colour,
    output logic [display_pkg::ADDR_W-1:0]    mem_addr,
    output display_pkg::pixel_t               pixel,
    output logic                              valid,
    output logic                              done
);
    import display_pkg::*;

    logic              busy;
    logic [BCOL_W-1:0] col;
    logic [BROW_W-1:0] row;
    logic              last;
    logic [X_W-1:0]    rd_x;
    logic [Y_W-1:0]    rd_y;

    // Coordinates of the read in flight
    logic              pend_valid;
    logic              pend_last;
    logic [X_W-1:0]    pend_x;
    logic [Y_W-1:0]    pend_y;

    assign last = (col == BCOL_W'(BANNER_W - 1)) && (row == BROW_W'(BANNER_H - 1));
    assign rd_x = X_W'(BANNER_X) + X_W'(col);
    assign rd_y = Y_W'(BANNER_Y) + Y_W'(row);

    assign mem_addr = ADDR_W'(rd_y) * ADDR_W'(SCREEN_W) + ADDR_W'(rd_x);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            col  <= '0;
            row  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            col  <= '0;
            row  <= '0;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
                col  <= '0;
                row  <= '0;
            end else if (col == BCOL_W'(BANNER_W - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Memory answers one clock later, so the coordinate waits one stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
        end else begin
            pend_valid <= busy;
            pend_last  <= busy && last;
        end
    end

    always_ff @(posedge clk) begin
        pend_x <= rd_x;
        pend_y <= rd_y;
    end

    always_comb begin
        pixel.colour = curr_colour;
        pixel.x      = pend_x;
        pixel.y      = pend_y;
    end

    assign valid = pend_valid;
    assign done  = pend_last;

endmodule

`default_nettype wire

// File: design/hold_timer.sv
`timescale 1ns/1ps
`default_nettype none

module hold_timer (
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic start,
    output logic      done
);
    import display_pkg::*;

    logic              armed;
    logic [HOLD_W-1:0] count;

    // Down counter, done lands HOLD_CYCLES clocks after start
    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed <= 1'b0;
            count <= '0;
        end else if (start) begin
            armed <= 1'b1;
            count <= HOLD_W'(HOLD_CYCLES - 1);
        end else if (armed) begin
            if (count == '0) begin
                armed <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = armed && (count == '0);

endmodule

`default_nettype wire

// File: design/screen_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module screen_sequencer (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  display_pkg::screen_e screen_sel,
    input  wire logic            draw_done,
    input  wire logic            hold_done,
    input  wire logic            restore_done,
    input  display_pkg::pixel_t  draw_pixel,
    input  display_pkg::pixel_t  restore_pixel,
    input  wire logic            draw_valid,
    input  wire logic            restore_valid,
    output logic                 draw_start,
    output logic                 hold_start,
    output logic                 restore_start,
    output display_pkg::screen_e active_screen,
    output display_pkg::pixel_t  pixel,
    output logic                 pixel_valid,
    output logic                 screen_done
);
    import display_pkg::*;

    typedef enum logic [2:0] {
        ph_idle,
        ph_draw,
        ph_hold,
        ph_restore,
        ph_done
    } phase_e;

    phase_e  phase;
    screen_e last_screen;
    logic    request;
    logic    keeps_overlay;
    pixel_t  sel_pixel;
    logic    sel_valid;

    assign request = (screen_sel != idle) && (screen_sel != last_screen);

    // Win and lose banners stay up, no hold or restore
    assign keeps_overlay = (active_screen == scr_win) || (active_screen == scr_lose);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase         <= ph_idle;
            active_screen <= idle;
            last_screen   <= idle;
            draw_start    <= 1'b0;
            hold_start    <= 1'b0;
            restore_start <= 1'b0;
            screen_done   <= 1'b0;
        end else begin
            draw_start    <= 1'b0;
            hold_start    <= 1'b0;
            restore_start <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (request) begin
                        active_screen <= screen_sel;
                        draw_start    <= 1'b1;
                        phase         <= ph_draw;
                    end
                end
                ph_draw: begin
                    if (draw_done) begin
                        if (keeps_overlay) begin
                            last_screen <= active_screen;
                            phase       <= ph_done;
                        end else begin
                            hold_start <= 1'b1;
                            phase      <= ph_hold;
                        end
                    end
                end
                ph_hold: begin
                    if (hold_done) begin
                        restore_start <= 1'b1;
                        phase         <= ph_restore;
                    end
                end
                ph_restore: begin
                    if (restore_done) begin
                        last_screen <= active_screen;
                        phase       <= ph_done;
                    end
                end
                ph_done: begin
                    // Level holds until the game moves off this screen
                    if (screen_sel != active_screen) begin
                        screen_done <= 1'b0;
                        phase       <= ph_idle;
                    end else begin
                        screen_done <= 1'b1;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    // Pick the stream of the current phase
    always_comb begin
        sel_pixel = draw_pixel;
        sel_valid = 1'b0;
        case (phase)
            ph_draw: sel_valid = draw_valid;
            ph_restore: begin
                sel_pixel = restore_pixel;
                sel_valid = restore_valid;
            end
            default: sel_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        pixel <= sel_pixel;
    end

endmodule

`default_nettype wire

// File: design/display_control_top.sv
`timescale 1ns/1ps
`default_nettype none

module display_control_top (
    input  wire logic                             clk,
    input  wire logic                             resetn,
    input  display_pkg::screen_e                  screen_sel,
    input  wire logic [display_pkg::COLOUR_W-1:0] curr_colour,
    output display_pkg::pixel_t                   pixel,
    output logic                                  pixel_valid,
    output logic [display_pkg::ADDR_W-1:0]        mem_addr,
    output logic                                  screen_done
);
    import display_pkg::*;

    screen_e active_screen;
    pixel_t  draw_pixel;
    pixel_t  restore_pixel;
    logic    draw_start;
    logic    draw_valid;
    logic    draw_done;
    logic    hold_start;
    logic    hold_done;
    logic    restore_start;
    logic    restore_valid;
    logic    restore_done;

    screen_sequencer u_sequencer (
        .clk           (clk),
        .resetn        (resetn),
        .screen_sel    (screen_sel),
        .draw_done     (draw_done),
        .hold_done     (hold_done),
        .restore_done  (restore_done),
        .draw_pixel    (draw_pixel),
        .restore_pixel (restore_pixel),
        .draw_valid    (draw_valid),
        .restore_valid (restore_valid),
        .draw_start    (draw_start),
        .hold_start    (hold_start),
        .restore_start (restore_start),
        .active_screen (active_screen),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid),
        .screen_done   (screen_done)
    );

    banner_drawer u_drawer (
        .clk    (clk),
        .resetn (resetn),
        .start  (draw_start),
        .screen (active_screen),
        .pixel  (draw_pixel),
        .valid  (draw_valid),
        .done   (draw_done)
    );

    // Reads back the map under the banner
    region_restorer u_restorer (
        .clk         (clk),
        .resetn      (resetn),
        .start       (restore_start),
        .curr_colour (curr_colour),
        .mem_addr    (mem_addr),
        .pixel       (restore_pixel),
        .valid       (restore_valid),
        .done        (restore_done)
    );

    hold_timer u_timer (
        .clk    (clk),
        .resetn (resetn),
        .start  (hold_start),
        .done   (hold_done)
    );

endmodule

`default_nettype wire

// File: dv/display_chk.sv
`timescale 1ns/1ps
`default_nettype none

module display_chk (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  display_pkg::screen_e screen_sel,
    input  display_pkg::pixel_t  pixel,
    input  wire logic            pixel_valid,
    input  wire logic            screen_done
);
    import display_pkg::*;

    // Every written pixel lands inside the overlay window
    a_in_window: assert property (@(posedge clk) disable iff (!resetn)
        pixel_valid |-> (pixel.x >= X_W'(BANNER_X)) && (pixel.x < X_W'(BANNER_X + BANNER_W))
            && (pixel.y >= Y_W'(BANNER_Y)) && (pixel.y < Y_W'(BANNER_Y + BANNER_H)))
        else $error("valid pixel outside the banner window");

    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        !(pixel_valid && screen_done))
        else $error("pixel_valid and screen_done high together");

    // Done may linger one clock after the select drops
    a_idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
        (screen_sel == idle) [*2] |-> !pixel_valid && !screen_done)
        else $error("output activity while screen_sel is idle");

    a_reset_quiet: assert property (@(posedge clk)
        !resetn |=> !pixel_valid && !screen_done)
        else $error("outputs not cleared by reset");

endmodule

bind display_control_top display_chk u_chk (
    .clk         (clk),
    .resetn      (resetn),
    .screen_sel  (screen_sel),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .screen_done (screen_done)
);

`default_nettype wire

// File: dv/display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module display_tb;
    import display_pkg::*;

    logic                clk;
    logic                resetn;
    screen_e             screen_sel;
    logic [COLOUR_W-1:0] curr_colour;
    pixel_t              pixel;
    logic                pixel_valid;
    logic [ADDR_W-1:0]   mem_addr;
    logic                screen_done;

    // Test table loaded from the stimulus file
    int     t_screen[$];
    int     t_restore[$];
    int     t_base[$];
    string  t_name[$];
    int     num_tests;
    logic   loaded;

    int     err_count;
    int     pass_count;
    pixel_t pix_q[$];
    int     gap_q[$];
    int     gap;
    logic   idle_prev;
    logic [ADDR_W-1:0] addr_seen;

    display_control_top DUT (
        .clk         (clk),
        .resetn      (resetn),
        .screen_sel  (screen_sel),
        .curr_colour (curr_colour),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .mem_addr    (mem_addr),
        .screen_done (screen_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Frame memory content of the current map, upper address bits folded in
    function automatic logic [COLOUR_W-1:0] frame_word(input logic [ADDR_W-1:0] addr);
        return addr[COLOUR_W-1:0] ^ COLOUR_W'(addr[ADDR_W-1:COLOUR_W]) ^ 9'h155;
    endfunction

    function automatic pixel_t expected_pixel(input int t, input int k);
        pixel_t p;
        int     idx;
        logic [ADDR_W-1:0] addr;
        idx = k % BANNER_PIXELS;
        p.x = X_W'(BANNER_X + idx % BANNER_W);
        p.y = Y_W'(BANNER_Y + idx / BANNER_W);
        if (k < BANNER_PIXELS) begin
            p.colour = COLOUR_W'(t_base[t]) ^ COLOUR_W'(idx);
        end else begin
            addr = ADDR_W'(p.y * SCREEN_W + p.x);
            p.colour = frame_word(addr);
        end
        return p;
    endfunction

    // Read data follows the address by one clock
    always @(negedge clk) begin
        addr_seen = mem_addr;
    end

    always @(posedge clk) begin
        #1 curr_colour = frame_word(addr_seen);
    end

    // Output monitor, sampled mid cycle
    always @(negedge clk) begin
        if (resetn && loaded) begin
            if (pixel_valid && screen_done) begin
                $display("pixel_valid and screen_done were high in the same cycle");
                err_count++;
            end
            if (screen_sel == idle && pixel_valid) begin
                $display("pixel_valid went high while screen_sel was idle");
                err_count++;
            end
            if (screen_sel == idle && idle_prev && screen_done) begin
                $display("screen_done was high while screen_sel was idle");
                err_count++;
            end
            if (pixel_valid) begin
                pix_q.push_back(pixel);
                gap_q.push_back(gap);
                gap = 0;
            end else begin
                gap++;
            end
            idle_prev = (screen_sel == idle);
        end
    end

    task automatic sample_step();
        @(negedge clk);
        #1;
    endtask

    task automatic run_test(input int t);
        int     errs_before;
        int     n_exp;
        int     k;
        pixel_t exp_px;
        errs_before = err_count;
        pix_q.delete();
        gap_q.delete();
        gap = 0;
        @(posedge clk);
        #1 screen_sel = screen_e'(t_screen[t]);
        do sample_step(); while (!screen_done);
        n_exp = t_restore[t] ? 2 * BANNER_PIXELS : BANNER_PIXELS;
        if (pix_q.size() != n_exp) begin
            $display("Error %s: pixel count expected %0d actual %0d",
                     t_name[t], n_exp, pix_q.size());
            err_count++;
        end
        for (k = 0; k < n_exp && k < pix_q.size(); k++) begin
            exp_px = expected_pixel(t, k);
            if (pix_q[k] != exp_px) begin
                $display("Error %s: pixel %0d expected %03h@(%0d,%0d) actual %03h@(%0d,%0d)",
                         t_name[t], k, exp_px.colour, exp_px.x, exp_px.y,
                         pix_q[k].colour, pix_q[k].x, pix_q[k].y);
                err_count++;
            end
        end
        if (t_restore[t] && gap_q.size() > BANNER_PIXELS
                && gap_q[BANNER_PIXELS] < HOLD_CYCLES) begin
            $display("Error %s: hold gap expected at least %0d actual %0d",
                     t_name[t], HOLD_CYCLES, gap_q[BANNER_PIXELS]);
            err_count++;
        end
        // Done level must hold while the screen stays selected
        repeat (4) begin
            sample_step();
            if (!screen_done) begin
                $display("%s: screen_done dropped while screen_sel was held", t_name[t]);
                err_count++;
            end
        end
        if (pix_q.size() != n_exp) begin
            $display("%s: pixels were written after screen_done", t_name[t]);
            err_count++;
        end
        @(posedge clk);
        #1 screen_sel = idle;
        repeat (3) sample_step();
        if (screen_done) begin
            $display("%s: screen_done stayed high after screen_sel returned to idle", t_name[t]);
            err_count++;
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("%s: passed", t_name[t]);
        end else begin
            $display("%s: failed", t_name[t]);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    scr;
        int    rst;
        int    base;
        int    t;
        string line;
        string name;
        resetn      = 1'b0;
        screen_sel  = idle;
        curr_colour = '0;
        loaded      = 1'b0;
        err_count   = 0;
        pass_count  = 0;
        gap         = 0;
        idle_prev   = 1'b1;
        addr_seen   = '0;
        fd = $fopen("dv/display_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/display_stim.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%d %d %h %s", scr, rst, base, name);
                    if (n == 4) begin
                        t_screen.push_back(scr);
                        t_restore.push_back(rst);
                        t_base.push_back(base);
                        t_name.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = t_screen.size();
        if (num_tests == 0) begin
            $display("No tests were found in the stimulus file");
            err_count++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        if (pixel_valid !== 1'b0 || screen_done !== 1'b0) begin
            $display("pixel_valid or screen_done was not low during reset");
            err_count++;
        end
        resetn = 1'b1;
        repeat (5) sample_step();
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, pass_count, num_tests - pass_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        int limit;
        wait (loaded);
        limit = num_tests * (BANNER_PIXELS * 2 + HOLD_CYCLES + 50) + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/display_stim.txt
# screen code (dec), restore expected (0/1), banner base colour (hex), test name
# base colour is the banner colour at window index 0; consecutive screens differ
1 1 1f8 start_screen
2 1 0c7 stage1_begin
3 1 038 stage1_clear
4 1 1c0 stage2_begin
5 1 03f stage2_clear
6 1 1b6 stage3_begin
7 1 0db stage3_clear
8 0 1ff win_screen
2 1 0c7 stage1_again
9 0 124 lose_screen
1 1 1f8 start_again

// File: files.f
design/display_pkg.sv
design/banner_drawer.sv
design/region_restorer.sv
design/hold_timer.sv
design/screen_sequencer.sv
design/display_control_top.sv
dv/display_chk.sv
dv/display_tb.sv

// File: Bender.yml
package:
  name: display_control

sources:
  - design/display_pkg.sv
  - design/banner_drawer.sv
  - design/region_restorer.sv
  - design/hold_timer.sv
  - design/screen_sequencer.sv
  - design/display_control_top.sv
  - target: simulation
    files:
      - dv/display_chk.sv
      - dv/display_tb.sv
